// File: logic/core_pkg.sv
////////////////////
// Core package
// Widths, opcodes, host address map and the structs shared by the
// multi-channel integer core
////////////////////
`default_nettype none

package core_pkg;

    localparam int data_width      = 32;
    localparam int reg_addr_width  = 4;
    localparam int channel_width   = 2;
    localparam int max_channels    = 4;
    localparam int store_depth     = 256;
    localparam int pc_width        = 8;
    localparam int reg_full_width  = channel_width + reg_addr_width;
    localparam int imm_width       = 24;
    localparam int host_addr_width = 16;

    // Register offsets inside the config region
    localparam int cfg_program_size = 0;
    localparam int cfg_n_channels   = 1;

    // Codes 8 to 15 are illegal
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_shl  = 4'd5,
        op_ldi  = 4'd6,
        op_stop = 4'd7
    } opcode_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [reg_addr_width-1:0] dest;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
        logic [15:0]               unused;
    } reg_format_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [reg_addr_width-1:0] dest;
        logic [imm_width-1:0]      imm;
    } imm_format_t;

    // One instruction word, two views
    typedef union packed {
        reg_format_t reg_format;
        imm_format_t imm_format;
    } instruction_t;

    // Host address bits 15 to 14
    typedef enum logic [1:0] {
        region_store  = 2'd0,
        region_regs   = 2'd1,
        region_config = 2'd2
    } region_t;

    typedef struct packed {
        logic                       write;
        logic [host_addr_width-1:0] addr;
        logic [data_width-1:0]      data;
    } host_req_t;

    typedef struct packed {
        logic [data_width-1:0] data;
    } host_rsp_t;

    typedef struct packed {
        logic                      enable;
        logic [reg_full_width-1:0] addr;
        logic [data_width-1:0]     data;
    } reg_write_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [reg_full_width-1:0] src_a;
        logic [reg_full_width-1:0] src_b;
        logic [reg_full_width-1:0] dest;
        logic [data_width-1:0]     imm;
        logic                      valid;
    } issue_t;

endpackage

`default_nettype wire

// File: logic/instruction_store.sv
////////////////////
// Instruction store
// Program memory, host write port, synchronous read at the pc
////////////////////
`timescale 1ns/100ps
`default_nettype none

module instruction_store (
    input  wire                              clock,
    input  wire                              write_enable,
    input  wire [core_pkg::pc_width-1:0]     write_index,
    input  wire [core_pkg::data_width-1:0]   write_data,
    input  wire [core_pkg::pc_width-1:0]     pc,
    output core_pkg::instruction_t           instruction
);

    logic [core_pkg::data_width-1:0] memory [core_pkg::store_depth];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_index] <= write_data;
        end
    end

    // One cycle from pc to instruction
    always_ff @(posedge clock) begin
        instruction <= memory[pc];
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
////////////////////
// Register file
// Sixteen registers per channel, two synchronous operand ports,
// ALU and host write ports and a host read port
////////////////////
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire                                 clock,
    input  wire  [core_pkg::reg_full_width-1:0] read_addr_a,
    input  wire  [core_pkg::reg_full_width-1:0] read_addr_b,
    output logic [core_pkg::data_width-1:0]     read_data_a,
    output logic [core_pkg::data_width-1:0]     read_data_b,
    input  wire core_pkg::reg_write_t           alu_write,
    input  wire core_pkg::reg_write_t           host_write,
    input  wire  [core_pkg::reg_full_width-1:0] host_read_addr,
    output logic [core_pkg::data_width-1:0]     host_read_data
);

    logic [core_pkg::data_width-1:0] registers [core_pkg::max_channels * 16];

    // ALU writeback has priority over the host
    always_ff @(posedge clock) begin
        if (alu_write.enable) begin
            registers[alu_write.addr] <= alu_write.data;
        end else if (host_write.enable) begin
            registers[host_write.addr] <= host_write.data;
        end
    end

    always_ff @(posedge clock) begin
        read_data_a <= registers[read_addr_a];
        read_data_b <= registers[read_addr_b];
    end

    // Host side reads without delay, the response stage registers it
    assign host_read_data = registers[host_read_addr];

endmodule

`default_nettype wire

// File: logic/alu.sv
////////////////////
// ALU
// Two-stage integer execute, result then writeback
////////////////////
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire                             clock,
    input  wire                             rst_n,
    input  wire core_pkg::issue_t           decoded,
    input  wire [core_pkg::data_width-1:0]  operand_a,
    input  wire [core_pkg::data_width-1:0]  operand_b,
    output core_pkg::reg_write_t            writeback
);

    logic [core_pkg::data_width-1:0]     result;
    logic                                s1_valid;
    logic [core_pkg::reg_full_width-1:0] s1_dest;
    logic [core_pkg::data_width-1:0]     s1_data;

    ////////////////////
    // Stage one
    ////////////////////
    always_comb begin
        case (decoded.opcode)
            core_pkg::op_add: result = operand_a + operand_b;
            core_pkg::op_sub: result = operand_a - operand_b;
            core_pkg::op_and: result = operand_a & operand_b;
            core_pkg::op_or:  result = operand_a | operand_b;
            core_pkg::op_xor: result = operand_a ^ operand_b;
            core_pkg::op_shl: result = operand_a << operand_b[4:0];
            core_pkg::op_ldi: result = decoded.imm;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= decoded.valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_dest <= decoded.dest;
        s1_data <= result;
    end

    ////////////////////
    // Stage two
    ////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            writeback <= '0;
        end else begin
            writeback.enable <= s1_valid;
            writeback.addr   <= s1_dest;
            writeback.data   <= s1_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/instruction_decoder.sv
////////////////////
// Instruction decoder
// Picks the instruction view from the opcode, adds the channel to
// the register indices and flags stop and illegal codes
////////////////////
`timescale 1ns/100ps
`default_nettype none

module instruction_decoder (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire core_pkg::instruction_t         instruction,
    input  wire  [core_pkg::channel_width-1:0]  channel,
    input  wire                                 issue,
    output logic [core_pkg::reg_full_width-1:0] read_addr_a,
    output logic [core_pkg::reg_full_width-1:0] read_addr_b,
    output core_pkg::issue_t                    decoded,
    output logic                                stop_seen,
    output logic                                illegal_seen
);

    logic             issue_d;
    core_pkg::issue_t next_issue;

    // Instruction word is valid one cycle after issue
    assign stop_seen    = issue_d && instruction.reg_format.opcode == core_pkg::op_stop;
    assign illegal_seen = issue_d && instruction.reg_format.opcode[3];

    always_comb begin
        next_issue        = '0;
        next_issue.opcode = instruction.reg_format.opcode;
        // Destination sits in the same bits in both views
        next_issue.dest   = {channel, instruction.reg_format.dest};
        if (instruction.reg_format.opcode == core_pkg::op_ldi) begin
            next_issue.imm  = {{(core_pkg::data_width-core_pkg::imm_width){
                instruction.imm_format.imm[core_pkg::imm_width-1]}},
                instruction.imm_format.imm};
        end else begin
            next_issue.src_a = {channel, instruction.reg_format.src_a};
            next_issue.src_b = {channel, instruction.reg_format.src_b};
        end
        next_issue.valid = issue_d && !stop_seen && !illegal_seen;
    end

    // Register file reads on the same edge that latches the decode
    assign read_addr_a = next_issue.src_a;
    assign read_addr_b = next_issue.src_b;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            issue_d <= 1'b0;
            decoded <= '0;
        end else begin
            issue_d <= issue;
            decoded <= next_issue;
        end
    end

endmodule

`default_nettype wire

// File: logic/control_unit.sv
////////////////////
// Control unit
// Run sequencer that walks every channel of every instruction,
// one at a time, and ends with done or fault
////////////////////
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  wire                                clock,
    input  wire                                rst_n,
    input  wire                                run,
    input  wire  [core_pkg::pc_width:0]        program_size,
    input  wire  [core_pkg::channel_width:0]   n_channels,
    input  wire                                stop_seen,
    input  wire                                illegal_seen,
    input  wire                                writeback_seen,
    output logic [core_pkg::pc_width-1:0]      pc,
    output logic [core_pkg::channel_width-1:0] channel,
    output logic                               issue,
    output logic                               busy,
    output logic                               done,
    output logic                               fault
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait
    } state_t;

    state_t state;
    logic   last_channel;
    logic   last_pc;

    assign last_channel = {1'b0, channel} == n_channels - 1'b1;
    assign last_pc      = {1'b0, pc} == program_size - 1'b1;

    assign issue = state == st_issue;
    assign busy  = state != st_idle;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= st_idle;
            pc      <= '0;
            channel <= '0;
            done    <= 1'b0;
            fault   <= 1'b0;
        end else begin
            done  <= 1'b0;
            fault <= 1'b0;
            case (state)
                st_idle: begin
                    if (run) begin
                        pc      <= '0;
                        channel <= '0;
                        state   <= st_issue;
                    end
                end
                st_issue: state <= st_wait;
                st_wait: begin
                    // Decode flags arrive one cycle after issue
                    if (illegal_seen) begin
                        fault <= 1'b1;
                        state <= st_idle;
                    end else if (stop_seen) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end else if (writeback_seen) begin
                        if (!last_channel) begin
                            channel <= channel + 1'b1;
                            state   <= st_issue;
                        end else if (!last_pc) begin
                            channel <= '0;
                            pc      <= pc + 1'b1;
                            state   <= st_issue;
                        end else begin
                            channel <= '0;
                            done    <= 1'b1;
                            state   <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/host_interface.sv
////////////////////
// Host interface
// Turns host requests into store, register and config writes,
// holds the config registers and returns one response per read
////////////////////
`timescale 1ns/100ps
`default_nettype none

module host_interface (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire core_pkg::host_req_t            host_req,
    input  wire                                 host_req_valid,
    output logic                                host_req_ready,
    output core_pkg::host_rsp_t                 host_rsp,
    output logic                                host_rsp_valid,
    input  wire                                 host_rsp_ready,
    input  wire                                 busy,
    output logic                                store_write_enable,
    output logic [core_pkg::pc_width-1:0]       store_write_index,
    output logic [core_pkg::data_width-1:0]     store_write_data,
    output core_pkg::reg_write_t                reg_write,
    output logic [core_pkg::reg_full_width-1:0] reg_read_addr,
    input  wire  [core_pkg::data_width-1:0]     reg_read_data,
    output logic [core_pkg::pc_width:0]         program_size,
    output logic [core_pkg::channel_width:0]    n_channels
);

    logic                            ready_en;
    logic                            accept;
    logic                            config_write;
    core_pkg::region_t               region;
    logic [13:0]                     cfg_addr;
    logic [core_pkg::pc_width:0]     size_value;
    logic [core_pkg::channel_width:0] count_value;
    logic [core_pkg::data_width-1:0] read_value;

    assign region   = core_pkg::region_t'(host_req.addr[15:14]);
    assign cfg_addr = host_req.addr[13:0];

    // No requests while running or while a response waits
    assign host_req_ready = ready_en && !busy && !host_rsp_valid;
    assign accept         = host_req_valid && host_req_ready;
    assign config_write   = accept && host_req.write && region == core_pkg::region_config;

    assign store_write_enable = accept && host_req.write && region == core_pkg::region_store;
    assign store_write_index  = host_req.addr[core_pkg::pc_width-1:0];
    assign store_write_data   = host_req.data;

    assign reg_write.enable = accept && host_req.write && region == core_pkg::region_regs;
    assign reg_write.addr   = host_req.addr[core_pkg::reg_full_width-1:0];
    assign reg_write.data   = host_req.data;
    assign reg_read_addr    = host_req.addr[core_pkg::reg_full_width-1:0];

    // Clamp config values into their legal ranges
    always_comb begin
        size_value  = host_req.data[core_pkg::pc_width:0];
        count_value = host_req.data[core_pkg::channel_width:0];
        if (host_req.data == '0) begin
            size_value = 1;
        end else if (host_req.data > core_pkg::store_depth) begin
            size_value = (core_pkg::pc_width+1)'(core_pkg::store_depth);
        end
        if (host_req.data == '0) begin
            count_value = 1;
        end else if (host_req.data > core_pkg::max_channels) begin
            count_value = (core_pkg::channel_width+1)'(core_pkg::max_channels);
        end
    end

    // Store is write-only and reads back as zero
    always_comb begin
        read_value = '0;
        case (region)
            core_pkg::region_regs: read_value = reg_read_data;
            core_pkg::region_config: begin
                if (cfg_addr == core_pkg::cfg_program_size) begin
                    read_value = {{(core_pkg::data_width-core_pkg::pc_width-1){1'b0}}, program_size};
                end else if (cfg_addr == core_pkg::cfg_n_channels) begin
                    read_value = {{(core_pkg::data_width-core_pkg::channel_width-1){1'b0}}, n_channels};
                end
            end
            default: read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ready_en       <= 1'b0;
            host_rsp_valid <= 1'b0;
            program_size   <= 1;
            n_channels     <= 1;
        end else begin
            ready_en <= 1'b1;
            if (config_write && cfg_addr == core_pkg::cfg_program_size) begin
                program_size <= size_value;
            end
            if (config_write && cfg_addr == core_pkg::cfg_n_channels) begin
                n_channels <= count_value;
            end
            if (accept && !host_req.write) begin
                host_rsp_valid <= 1'b1;
            end else if (host_rsp_ready) begin
                host_rsp_valid <= 1'b0;
            end
        end
    end

    // Response data stays put under back-pressure
    always_ff @(posedge clock) begin
        if (accept && !host_req.write) begin
            host_rsp.data <= read_value;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_top.sv
////////////////////
// Core top level
// Host interface, instruction store, sequencer, decoder,
// register file and ALU of the multi-channel integer core
////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_top (
    input  wire                      clock,
    input  wire                      rst_n,
    input  wire                      run,
    output logic                     busy,
    output logic                     done,
    output logic                     fault,
    input  wire core_pkg::host_req_t host_req,
    input  wire                      host_req_valid,
    output logic                     host_req_ready,
    output core_pkg::host_rsp_t      host_rsp,
    output logic                     host_rsp_valid,
    input  wire                      host_rsp_ready
);

    logic                                store_write_enable;
    logic [core_pkg::pc_width-1:0]       store_write_index;
    logic [core_pkg::data_width-1:0]     store_write_data;
    core_pkg::reg_write_t                host_write;
    logic [core_pkg::reg_full_width-1:0] host_read_addr;
    logic [core_pkg::data_width-1:0]     host_read_data;
    logic [core_pkg::pc_width:0]         program_size;
    logic [core_pkg::channel_width:0]    n_channels;

    logic [core_pkg::pc_width-1:0]       pc;
    logic [core_pkg::channel_width-1:0]  channel;
    logic                                issue;
    logic                                stop_seen;
    logic                                illegal_seen;
    core_pkg::instruction_t              instruction;

    logic [core_pkg::reg_full_width-1:0] read_addr_a;
    logic [core_pkg::reg_full_width-1:0] read_addr_b;
    logic [core_pkg::data_width-1:0]     read_data_a;
    logic [core_pkg::data_width-1:0]     read_data_b;
    core_pkg::issue_t                    decoded;
    core_pkg::reg_write_t                writeback;

    host_interface i_host_interface (
        .clock, .rst_n, .host_req, .host_req_valid, .host_req_ready,
        .host_rsp, .host_rsp_valid, .host_rsp_ready, .busy,
        .store_write_enable, .store_write_index, .store_write_data,
        .reg_write(host_write), .reg_read_addr(host_read_addr),
        .reg_read_data(host_read_data), .program_size, .n_channels
    );

    instruction_store i_instruction_store (
        .clock, .write_enable(store_write_enable), .write_index(store_write_index),
        .write_data(store_write_data), .pc, .instruction
    );

    control_unit i_control_unit (
        .clock, .rst_n, .run, .program_size, .n_channels, .stop_seen,
        .illegal_seen, .writeback_seen(writeback.enable), .pc, .channel,
        .issue, .busy, .done, .fault
    );

    instruction_decoder i_instruction_decoder (
        .clock, .rst_n, .instruction, .channel, .issue, .read_addr_a,
        .read_addr_b, .decoded, .stop_seen, .illegal_seen
    );

    register_file i_register_file (
        .clock, .read_addr_a, .read_addr_b, .read_data_a, .read_data_b,
        .alu_write(writeback), .host_write, .host_read_addr, .host_read_data
    );

    alu i_alu (
        .clock, .rst_n, .decoded, .operand_a(read_data_a),
        .operand_b(read_data_b), .writeback
    );

endmodule

`default_nettype wire

// File: verification/core_clock_gen.sv
////////////////////
// Clock generator
// 40 ns clock and a reset held low for four cycles
////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_clock_gen (
    output logic clock,
    output logic rst_n
);

    localparam int half_period = 20;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/core_chk.sv
////////////////////
// Core checker
// Concurrent assertions on the run handshake, the host streams
// and the register readback against the testbench model
////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_chk (
    input wire                      clock,
    input wire                      rst_n,
    input wire                      run,
    input wire                      busy,
    input wire                      done,
    input wire                      fault,
    input wire                      host_req_valid,
    input wire                      host_req_ready,
    input wire core_pkg::host_rsp_t host_rsp,
    input wire                      host_rsp_valid,
    input wire                      host_rsp_ready,
    input wire [31:0]               expected_data,
    input wire                      fault_expected
);

    int failure_count = 0;

    // Outputs quiet on the first cycle out of reset
    reset_state: assert property (@(posedge clock)
        $rose(rst_n) |-> !busy && !done && !fault && !host_req_ready && !host_rsp_valid)
        else begin
            $error("Outputs not idle after reset");
            failure_count++;
        end

    busy_needs_run: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(busy) |-> $past(run))
        else begin
            $error("busy rose without a run pulse");
            failure_count++;
        end

    end_needs_busy: assert property (@(posedge clock) disable iff (!rst_n)
        (done || fault) |-> $past(busy) && !(done && fault))
        else begin
            $error("done or fault outside a run, or both together");
            failure_count++;
        end

    end_is_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        (done || fault) |=> !(done || fault))
        else begin
            $error("done or fault held longer than one cycle");
            failure_count++;
        end

    // Which of the two ends the current program must take
    end_kind: assert property (@(posedge clock) disable iff (!rst_n)
        (done || fault) |-> fault == fault_expected)
        else begin
            $error("Run ended with the wrong one of done and fault");
            failure_count++;
        end

    // A pending request is refused for the whole run
    no_accept_busy: assert property (@(posedge clock) disable iff (!rst_n)
        busy && host_req_valid |-> !host_req_ready)
        else begin
            $error("Host request accepted while the core is busy");
            failure_count++;
        end

    rsp_hold: assert property (@(posedge clock) disable iff (!rst_n)
        host_rsp_valid && !host_rsp_ready |=> host_rsp_valid && $stable(host_rsp))
        else begin
            $error("Response dropped or changed under back-pressure");
            failure_count++;
        end

    read_value: assert property (@(posedge clock) disable iff (!rst_n)
        host_rsp_valid && host_rsp_ready |-> host_rsp.data == expected_data)
        else begin
            $error("FAIL host_rsp.data %h expected %h",
                $sampled(host_rsp.data), $sampled(expected_data));
            failure_count++;
        end

endmodule

`default_nettype wire

// File: verification/core_tb.sv
////////////////////
// Core testbench
// Host driver, register model, programs for the run, stop and
// fault cases, full register readback and a cycle limit
////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_tb;

    // Per phase a preload, a readback with hold cycles and a 7 x 4 run
    localparam int phase_cycles   = 64 + 64 * 5 + 7 * 4 * 6;
    localparam int timeout_cycles = 8 * phase_cycles;

    logic                clock;
    logic                rst_n;
    logic                run;
    logic                busy;
    logic                done;
    logic                fault;
    core_pkg::host_req_t host_req;
    logic                host_req_valid;
    logic                host_req_ready;
    core_pkg::host_rsp_t host_rsp;
    logic                host_rsp_valid;
    logic                host_rsp_ready;

    // Reference values shared with the checker
    logic [31:0] expected_data;
    logic        fault_expected;

    logic [31:0]         model [64];
    core_pkg::opcode_t   prog_op [8];
    logic [3:0]          prog_d [8];
    logic [3:0]          prog_a [8];
    logic [3:0]          prog_b [8];
    logic [23:0]         prog_imm [8];
    integer              seed;
    int                  cycle_count = 0;

    core_clock_gen i_core_clock_gen (.clock, .rst_n);

    core_top i_core_top (
        .clock, .rst_n, .run, .busy, .done, .fault, .host_req, .host_req_valid,
        .host_req_ready, .host_rsp, .host_rsp_valid, .host_rsp_ready
    );

    bind core_top core_chk i_core_chk (
        .clock, .rst_n, .run, .busy, .done, .fault, .host_req_valid, .host_req_ready,
        .host_rsp, .host_rsp_valid, .host_rsp_ready,
        .expected_data(core_tb.expected_data), .fault_expected(core_tb.fault_expected)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Done: errors found");
            $fatal(1, "Timeout after %0d cycles", cycle_count);
        end
    end

    always @(negedge clock) begin
        if (i_core_top.i_core_chk.failure_count != 0) begin
            $display("Done: errors found");
            $fatal(1, "Checker assertion failed");
        end
    end

    ////////////////////
    // Host driver
    ////////////////////
    function automatic logic [15:0] reg_addr(input int index);
        return {2'b01, 8'h00, index[5:0]};
    endfunction

    task automatic wait_accept();
        while (!host_req_ready) @(negedge clock);
        @(posedge clock);
        @(negedge clock);
        host_req_valid = 1'b0;
    endtask

    task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
        host_req.write = 1'b1;
        host_req.addr  = addr;
        host_req.data  = data;
        host_req_valid = 1'b1;
        wait_accept();
    endtask

    task automatic start_read(input logic [15:0] addr, input logic [31:0] expected);
        host_req.write = 1'b0;
        host_req.addr  = addr;
        host_req.data  = '0;
        expected_data  = expected;
        host_req_valid = 1'b1;
    endtask

    // Response ready stays low for hold cycles first
    task automatic finish_read(input int hold);
        wait_accept();
        repeat (hold) @(negedge clock);
        host_rsp_ready = 1'b1;
        while (!host_rsp_valid) @(negedge clock);
        @(posedge clock);
        @(negedge clock);
        host_rsp_ready = 1'b0;
    endtask

    task automatic host_read(input logic [15:0] addr, input logic [31:0] expected,
                             input int hold);
        start_read(addr, expected);
        finish_read(hold);
    endtask

    task automatic set_config(input int size, input int n_ch);
        host_write({2'b10, 14'd0}, size);
        host_write({2'b10, 14'd1}, n_ch);
    endtask

    ////////////////////
    // Program and model
    ////////////////////
    task automatic load_instr(input int index, input core_pkg::opcode_t op,
                              input logic [3:0] d, input logic [3:0] a,
                              input logic [3:0] b, input logic [23:0] imm);
        logic [31:0] word;
        prog_op[index]  = op;
        prog_d[index]   = d;
        prog_a[index]   = a;
        prog_b[index]   = b;
        prog_imm[index] = imm;
        if (op == core_pkg::op_ldi) begin
            word = {op, d, imm};
        end else begin
            word = {op, d, a, b, 16'h0000};
        end
        host_write({2'b00, 6'h00, index[7:0]}, word);
    endtask

    function automatic logic [31:0] expected_result(input core_pkg::opcode_t op,
            input logic [31:0] a, input logic [31:0] b, input logic [23:0] imm);
        case (op)
            core_pkg::op_add: return a + b;
            core_pkg::op_sub: return a - b;
            core_pkg::op_and: return a & b;
            core_pkg::op_or:  return a | b;
            core_pkg::op_xor: return a ^ b;
            core_pkg::op_shl: return a << b[4:0];
            core_pkg::op_ldi: return {{8{imm[23]}}, imm};
            default:          return 32'h0;
        endcase
    endfunction

    // Stop and illegal codes end the run for every channel
    task automatic model_run(input int size, input int n_ch);
        logic [5:0] a;
        logic [5:0] b;
        logic [5:0] d;
        for (int pc = 0; pc < size; pc++) begin
            if (prog_op[pc] == core_pkg::op_stop || prog_op[pc][3]) break;
            for (int ch = 0; ch < n_ch; ch++) begin
                a = {ch[1:0], prog_a[pc]};
                b = {ch[1:0], prog_b[pc]};
                d = {ch[1:0], prog_d[pc]};
                model[d] = expected_result(prog_op[pc], model[a], model[b], prog_imm[pc]);
            end
        end
    endtask

    task automatic preload_random();
        for (int i = 0; i < 64; i++) begin
            model[i] = $random(seed);
            host_write(reg_addr(i), model[i]);
        end
    endtask

    task automatic readback_all();
        for (int i = 0; i < 64; i++) begin
            host_read(reg_addr(i), model[i], i % 3);
        end
    endtask

    // A config read waits behind the run, refused while busy
    task automatic run_program(input int n_ch);
        run = 1'b1;
        @(negedge clock);
        run = 1'b0;
        start_read({2'b10, 14'd1}, n_ch);
        while (!(done || fault)) @(negedge clock);
        finish_read(0);
    endtask

    initial begin
        seed           = 75287;
        run            = 1'b0;
        host_req       = '0;
        host_req_valid = 1'b0;
        host_rsp_ready = 1'b0;
        expected_data  = '0;
        fault_expected = 1'b0;
        @(posedge rst_n);
        repeat (6) @(negedge clock);

        // Defaults after reset, store reads as zero
        host_read({2'b10, 14'd0}, 32'd1, 0);
        host_read({2'b10, 14'd1}, 32'd1, 2);
        host_read({2'b00, 14'd5}, 32'd0, 1);

        // All operations on four channels
        load_instr(0, core_pkg::op_ldi, 4'd1, 4'd0, 4'd0, 24'($random(seed)));
        load_instr(1, core_pkg::op_add, 4'd2, 4'd3, 4'd4, 24'h0);
        load_instr(2, core_pkg::op_sub, 4'd5, 4'd1, 4'd6, 24'h0);
        load_instr(3, core_pkg::op_and, 4'd7, 4'd2, 4'd8, 24'h0);
        load_instr(4, core_pkg::op_or,  4'd9, 4'd5, 4'd10, 24'h0);
        load_instr(5, core_pkg::op_xor, 4'd11, 4'd7, 4'd9, 24'h0);
        load_instr(6, core_pkg::op_shl, 4'd12, 4'd11, 4'd13, 24'h0);
        set_config(7, 4);
        preload_random();
        run_program(4);
        model_run(7, 4);
        readback_all();

        // Channels 2 and 3 stay untouched
        preload_random();
        set_config(7, 2);
        run_program(2);
        model_run(7, 2);
        readback_all();

        // Stop in the middle of the program
        load_instr(0, core_pkg::op_ldi, 4'd14, 4'd0, 4'd0, 24'h800123);
        load_instr(1, core_pkg::op_add, 4'd15, 4'd14, 4'd0, 24'h0);
        load_instr(2, core_pkg::op_shl, 4'd0, 4'd15, 4'd3, 24'h0);
        load_instr(3, core_pkg::op_stop, 4'd0, 4'd0, 4'd0, 24'h0);
        load_instr(4, core_pkg::op_ldi, 4'd2, 4'd0, 4'd0, 24'h00abcd);
        load_instr(5, core_pkg::op_xor, 4'd3, 4'd3, 4'd3, 24'h0);
        load_instr(6, core_pkg::op_sub, 4'd4, 4'd1, 4'd2, 24'h0);
        set_config(7, 4);
        run_program(4);
        model_run(7, 4);
        readback_all();

        // Illegal opcode raises fault
        load_instr(0, core_pkg::op_xor, 4'd4, 4'd5, 4'd6, 24'h0);
        load_instr(1, core_pkg::op_ldi, 4'd6, 4'd0, 4'd0, 24'h012345);
        load_instr(2, core_pkg::opcode_t'(4'hb), 4'd7, 4'd0, 4'd0, 24'h0);
        load_instr(3, core_pkg::op_ldi, 4'd4, 4'd0, 4'd0, 24'h7fffff);
        set_config(4, 3);
        fault_expected = 1'b1;
        run_program(3);
        fault_expected = 1'b0;
        model_run(4, 3);
        readback_all();

        repeat (4) @(negedge clock);
        if (i_core_top.i_core_chk.failure_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Checker reported %0d failures", i_core_top.i_core_chk.failure_count);
        end
    end

endmodule

`default_nettype wire

// File: core_top.f
logic/core_pkg.sv
logic/instruction_store.sv
logic/register_file.sv
logic/alu.sv
logic/instruction_decoder.sv
logic/control_unit.sv
logic/host_interface.sv
logic/core_top.sv
verification/core_clock_gen.sv
verification/core_chk.sv
verification/core_tb.sv
